/* hdl/sdma_data_buf.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sdma_defines.svh"

module sdma_data_buf import sdma_pkg::*; (
  input  logic       i_clk,
  input  logic       i_rst_n,
  input  logic       i_push,
  input  sdma_word_t i_data,
  input  logic       i_pop,
  output sdma_word_t o_data,
  output logic       o_empty
);

  localparam int PTR_W = $clog2(`SDMA_BUF_DEPTH);

  sdma_word_t     mem [`SDMA_BUF_DEPTH];
  logic [PTR_W:0] wr_ptr_q;
  logic [PTR_W:0] rd_ptr_q;

  // Extra pointer bit tells full from empty
  assign o_empty = (wr_ptr_q == rd_ptr_q);
  assign o_data  = mem[rd_ptr_q[PTR_W-1:0]];

  always_ff @(posedge i_clk) begin
    if (i_push) begin
      mem[wr_ptr_q[PTR_W-1:0]] <= i_data;
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (i_push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (i_pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* hdl/sdma_defines.svh */
`ifndef SDMA_DEFINES_SVH
`define SDMA_DEFINES_SVH

// Word, address and length widths
`define SDMA_DATA_W     32
`define SDMA_ADDR_W     16
`define SDMA_LEN_W      10

// op(2) src(2) dst(2) src_addr(16) dst_addr(16) len(10)
`define SDMA_INST_W     48

// Read data buffer, also the read credit limit
`define SDMA_BUF_DEPTH  4

// Weight cache windows
`define SDMA_WMEM_SADDR 16'h0000
`define SDMA_WMEM_EADDR 16'h0FFF
`define SDMA_BMEM_SADDR 16'h1000
`define SDMA_BMEM_EADDR 16'h13FF

`endif

/* hdl/sdma_inst_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sdma_defines.svh"

module sdma_inst_ctrl import sdma_pkg::*; (
  input  logic                    i_clk,
  input  logic                    i_rst_n,
  input  logic                    i_sdma_en,
  input  logic                    i_sdma_inst_vld,
  input  logic [`SDMA_INST_W-1:0] i_sdma_inst,
  input  logic                    i_move_done,
  output logic                    o_sdma_ready,
  output logic                    o_sdma_done,
  output logic                    o_sdma_err,
  output logic                    o_start,
  output sdma_op_e                o_op,
  output sdma_port_e              o_src_port,
  output sdma_port_e              o_dst_port,
  output sdma_addr_t              o_src_addr,
  output sdma_addr_t              o_dst_addr,
  output sdma_len_t               o_len
);

  // Field positions, length in the low bits
  localparam int DST_A_LSB = `SDMA_LEN_W;
  localparam int SRC_A_LSB = DST_A_LSB + `SDMA_ADDR_W;
  localparam int DST_P_LSB = SRC_A_LSB + `SDMA_ADDR_W;
  localparam int SRC_P_LSB = DST_P_LSB + 2;
  localparam int OP_LSB    = SRC_P_LSB + 2;

  sdma_state_e state_q;
  sdma_state_e state_d;
  logic        ready_q;
  logic        accept;
  logic        inst_bad;
  logic        len_zero;
  sdma_op_e    in_op;
  sdma_port_e  in_src;
  sdma_port_e  in_dst;

  assign in_op  = sdma_op_e'(i_sdma_inst[OP_LSB +: 2]);
  assign in_src = sdma_port_e'(i_sdma_inst[SRC_P_LSB +: 2]);
  assign in_dst = sdma_port_e'(i_sdma_inst[DST_P_LSB +: 2]);

  assign accept   = i_sdma_inst_vld & ready_q;
  assign len_zero = (i_sdma_inst[`SDMA_LEN_W-1:0] == '0);
  // Zero fill never reads, so only its destination matters
  assign inst_bad = (in_dst == port_rsvd) || ((in_op != op_zero) && (in_src == port_rsvd));

  assign o_sdma_ready = ready_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      st_idle: if (accept && !inst_bad && !len_zero) state_d = st_busy;
      st_busy: if (i_move_done) state_d = st_idle;
      default: state_d = st_idle;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      state_q     <= st_idle;
      ready_q     <= 1'b0;
      o_start     <= 1'b0;
      o_sdma_done <= 1'b0;
      o_sdma_err  <= 1'b0;
    end else begin
      state_q     <= state_d;
      // Ready drops on the accepting edge
      ready_q     <= i_sdma_en & (state_d == st_idle) & ~accept;
      o_start     <= accept & ~inst_bad & ~len_zero;
      o_sdma_done <= (accept & ~inst_bad & len_zero) | i_move_done;
      o_sdma_err  <= accept & inst_bad;
    end
  end

  always_ff @(posedge i_clk) begin
    if (accept) begin
      o_op       <= in_op;
      o_src_port <= in_src;
      o_dst_port <= in_dst;
      o_src_addr <= i_sdma_inst[SRC_A_LSB +: `SDMA_ADDR_W];
      o_dst_addr <= i_sdma_inst[DST_A_LSB +: `SDMA_ADDR_W];
      o_len      <= i_sdma_inst[`SDMA_LEN_W-1:0];
    end
  end

endmodule

`default_nettype wire

/* hdl/sdma_move_engine.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sdma_defines.svh"

module sdma_move_engine import sdma_pkg::*; (
  input  logic       i_clk,
  input  logic       i_rst_n,
  input  logic       i_start,
  input  logic [1:0] i_op,
  input  sdma_addr_t i_src_addr,
  input  sdma_addr_t i_dst_addr,
  input  sdma_len_t  i_len,
  input  logic       i_rd_ready,
  input  logic       i_rd_vld,
  input  logic       i_wr_ready,
  input  logic       i_buf_empty,
  output logic       o_rd_req,
  output sdma_addr_t o_rd_addr,
  output logic       o_wr_req,
  output sdma_addr_t o_wr_addr,
  output logic       o_wr_zero,
  output logic       o_buf_pop,
  output logic       o_move_done
);

  localparam int CNT_W = $clog2(`SDMA_BUF_DEPTH) + 1;

  sdma_addr_t       rd_addr_q;
  sdma_addr_t       wr_addr_q;
  sdma_len_t        rd_left_q;
  sdma_len_t        wr_left_q;
  logic [CNT_W-1:0] inflight_q;
  logic [CNT_W-1:0] held_q;
  logic [CNT_W-1:0] credit_used;
  logic             zero_op;
  logic             rd_acc;
  logic             wr_acc;

  assign zero_op = (i_op == op_zero);

  // Reads in flight plus words waiting in the buffer
  assign credit_used = inflight_q + held_q;

  // --------------------
  // Request channels
  // --------------------
  assign o_rd_req  = (rd_left_q != '0) && (credit_used < CNT_W'(`SDMA_BUF_DEPTH));
  assign o_rd_addr = rd_addr_q;
  assign rd_acc    = o_rd_req & i_rd_ready;

  assign o_wr_req  = (wr_left_q != '0) && (zero_op || !i_buf_empty);
  assign o_wr_addr = wr_addr_q;
  assign o_wr_zero = zero_op;
  assign wr_acc    = o_wr_req & i_wr_ready;

  assign o_buf_pop   = wr_acc & ~zero_op;
  assign o_move_done = wr_acc && (wr_left_q == sdma_len_t'(1));

  // --------------------
  // Word counters
  // --------------------
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      rd_left_q <= '0;
      wr_left_q <= '0;
    end else if (i_start) begin
      rd_left_q <= zero_op ? '0 : i_len;
      wr_left_q <= i_len;
    end else begin
      if (rd_acc) rd_left_q <= rd_left_q - 1'b1;
      if (wr_acc) wr_left_q <= wr_left_q - 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_start) begin
      rd_addr_q <= i_src_addr;
      wr_addr_q <= i_dst_addr;
    end else begin
      if (rd_acc) rd_addr_q <= rd_addr_q + 1'b1;
      if (wr_acc) wr_addr_q <= wr_addr_q + 1'b1;
    end
  end

  // Read credit, returned when the word leaves the buffer
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      inflight_q <= '0;
      held_q     <= '0;
    end else begin
      case ({rd_acc, i_rd_vld})
        2'b10:   inflight_q <= inflight_q + 1'b1;
        2'b01:   inflight_q <= inflight_q - 1'b1;
        default: inflight_q <= inflight_q;
      endcase
      case ({i_rd_vld, o_buf_pop})
        2'b10:   held_q <= held_q + 1'b1;
        2'b01:   held_q <= held_q - 1'b1;
        default: held_q <= held_q;
      endcase
    end
  end

endmodule

`default_nettype wire

/* hdl/sdma_pkg.sv */
`default_nettype none

`include "sdma_defines.svh"

package sdma_pkg;

  typedef enum logic [1:0] {
    op_move = 2'd0,
    op_zero = 2'd1
  } sdma_op_e;

  typedef enum logic [1:0] {
    port_ahb  = 2'd0,
    port_dc   = 2'd1,
    port_wc   = 2'd2,
    port_rsvd = 2'd3
  } sdma_port_e;

  typedef enum logic {
    st_idle = 1'b0,
    st_busy = 1'b1
  } sdma_state_e;

  typedef logic [`SDMA_DATA_W-1:0] sdma_word_t;
  typedef logic [`SDMA_ADDR_W-1:0] sdma_addr_t;
  typedef logic [`SDMA_LEN_W-1:0]  sdma_len_t;

endpackage

`default_nettype wire

/* hdl/sdma_port_mux.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sdma_defines.svh"

module sdma_port_mux import sdma_pkg::*; (
  input  logic       i_clk,
  input  logic       i_rst_n,
  input  logic [1:0] i_src_port,
  input  logic [1:0] i_dst_port,
  input  logic       i_rd_req,
  input  sdma_addr_t i_rd_addr,
  input  logic       i_wr_req,
  input  sdma_addr_t i_wr_addr,
  input  logic       i_wr_zero,
  input  sdma_word_t i_buf_data,
  output logic       o_rd_ready,
  output logic       o_wr_ready,
  output logic       o_rd_vld,
  output sdma_word_t o_rd_data,
  // external bus
  output logic       o_ahb_req,
  output logic       o_ahb_wea,
  output sdma_addr_t o_ahb_addr,
  output sdma_word_t o_ahb_wdata,
  input  logic       i_ahb_ready,
  input  logic       i_ahb_rvld,
  input  sdma_word_t i_ahb_rdata,
  // data cache
  output logic       o_dc_req,
  output logic       o_dc_wea,
  output sdma_addr_t o_dc_addr,
  output sdma_word_t o_dc_wdata,
  input  logic       i_dc_ready,
  input  logic       i_dc_rvld,
  input  sdma_word_t i_dc_rdata,
  // weight memory
  output logic       o_wm_req,
  output logic       o_wm_wea,
  output sdma_addr_t o_wm_addr,
  output sdma_word_t o_wm_wdata,
  input  logic       i_wm_ready,
  input  logic       i_wm_rvld,
  input  sdma_word_t i_wm_rdata,
  // bias memory
  output logic       o_bm_req,
  output logic       o_bm_wea,
  output sdma_addr_t o_bm_addr,
  output sdma_word_t o_bm_wdata,
  input  logic       i_bm_ready,
  input  logic       i_bm_rvld,
  input  sdma_word_t i_bm_rdata
);

  localparam int P_AHB = 0;
  localparam int P_DC  = 1;
  localparam int P_WM  = 2;
  localparam int P_BM  = 3;

  localparam sdma_addr_t W_SPAN = `SDMA_WMEM_EADDR - `SDMA_WMEM_SADDR;
  localparam sdma_addr_t B_SPAN = `SDMA_BMEM_EADDR - `SDMA_BMEM_SADDR;

  // One-hot physical target, all zero when absorbed
  function automatic logic [3:0] phys_sel(input logic [1:0] port, input sdma_addr_t addr);
    logic [3:0] sel;
    sdma_addr_t off_w;
    sdma_addr_t off_b;
    sel   = '0;
    off_w = addr - `SDMA_WMEM_SADDR;
    off_b = addr - `SDMA_BMEM_SADDR;
    case (port)
      port_ahb: sel[P_AHB] = 1'b1;
      port_dc:  sel[P_DC]  = 1'b1;
      port_wc: begin
        if (off_w <= W_SPAN) sel[P_WM] = 1'b1;
        else if (off_b <= B_SPAN) sel[P_BM] = 1'b1;
      end
      default: sel = '0;
    endcase
    return sel;
  endfunction

  function automatic sdma_addr_t phys_addr(input logic [3:0] sel, input sdma_addr_t addr);
    if (sel[P_WM]) return addr - `SDMA_WMEM_SADDR;
    if (sel[P_BM]) return addr - `SDMA_BMEM_SADDR;
    return addr;
  endfunction

  logic [3:0] rd_tgt;
  logic [3:0] wr_tgt;
  logic [3:0] rd_sel;
  logic [3:0] wr_sel;
  logic [3:0] port_ready;
  sdma_addr_t rd_addr_m;
  sdma_addr_t wr_addr_m;
  sdma_word_t wr_data;
  logic       clash;
  logic       rd_block;
  logic       wr_block;
  logic       rd_wait_q;
  logic       rd_absorb_q;

  assign rd_tgt    = phys_sel(i_src_port, i_rd_addr);
  assign wr_tgt    = phys_sel(i_dst_port, i_wr_addr);
  assign rd_addr_m = phys_addr(rd_tgt, i_rd_addr);
  assign wr_addr_m = phys_addr(wr_tgt, i_wr_addr);

  // --------------------
  // Arbitration
  // --------------------
  // Write wins a shared port, but a read left waiting keeps it
  assign clash    = i_rd_req & i_wr_req & (i_src_port == i_dst_port);
  assign rd_block = clash & ~rd_wait_q;
  assign wr_block = clash & rd_wait_q;

  assign rd_sel = (i_rd_req & ~rd_block) ? rd_tgt : 4'b0000;
  assign wr_sel = (i_wr_req & ~wr_block) ? wr_tgt : 4'b0000;

  assign port_ready = {i_bm_ready, i_wm_ready, i_dc_ready, i_ahb_ready};
  assign o_rd_ready = ~rd_block & ((rd_tgt == '0) | (|(rd_tgt & port_ready)));
  assign o_wr_ready = ~wr_block & ((wr_tgt == '0) | (|(wr_tgt & port_ready)));

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      rd_wait_q   <= 1'b0;
      rd_absorb_q <= 1'b0;
    end else begin
      rd_wait_q   <= i_rd_req & ~rd_block & ~o_rd_ready;
      // Absorbed read answers zero one cycle later
      rd_absorb_q <= i_rd_req & o_rd_ready & (rd_tgt == '0) & (i_src_port == port_wc);
    end
  end

  // --------------------
  // Port drive
  // --------------------
  assign wr_data = i_wr_zero ? '0 : i_buf_data;

  assign o_ahb_req   = rd_sel[P_AHB] | wr_sel[P_AHB];
  assign o_ahb_wea   = wr_sel[P_AHB];
  assign o_ahb_addr  = wr_sel[P_AHB] ? wr_addr_m : rd_addr_m;
  assign o_ahb_wdata = wr_data;

  assign o_dc_req    = rd_sel[P_DC] | wr_sel[P_DC];
  assign o_dc_wea    = wr_sel[P_DC];
  assign o_dc_addr   = wr_sel[P_DC] ? wr_addr_m : rd_addr_m;
  assign o_dc_wdata  = wr_data;

  assign o_wm_req    = rd_sel[P_WM] | wr_sel[P_WM];
  assign o_wm_wea    = wr_sel[P_WM];
  assign o_wm_addr   = wr_sel[P_WM] ? wr_addr_m : rd_addr_m;
  assign o_wm_wdata  = wr_data;

  assign o_bm_req    = rd_sel[P_BM] | wr_sel[P_BM];
  assign o_bm_wea    = wr_sel[P_BM];
  assign o_bm_addr   = wr_sel[P_BM] ? wr_addr_m : rd_addr_m;
  assign o_bm_wdata  = wr_data;

  // Read return from the source port
  always_comb begin
    o_rd_vld  = 1'b0;
    o_rd_data = '0;
    case (i_src_port)
      port_ahb: begin
        o_rd_vld  = i_ahb_rvld;
        o_rd_data = i_ahb_rdata;
      end
      port_dc: begin
        o_rd_vld  = i_dc_rvld;
        o_rd_data = i_dc_rdata;
      end
      port_wc: begin
        o_rd_vld = i_wm_rvld | i_bm_rvld | rd_absorb_q;
        if (i_wm_rvld) o_rd_data = i_wm_rdata;
        else if (i_bm_rvld) o_rd_data = i_bm_rdata;
      end
      default: o_rd_vld = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

/* hdl/sdma_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sdma_defines.svh"

module sdma_top (
  input  logic                    i_clk,
  input  logic                    i_rst_n,
  input  logic                    i_sdma_en,
  input  logic                    i_sdma_inst_vld,
  input  logic [`SDMA_INST_W-1:0] i_sdma_inst,
  output logic                    o_sdma_ready,
  output logic                    o_sdma_done,
  output logic                    o_sdma_err,
  // external bus
  output logic                    o_ahb_req,
  output logic                    o_ahb_wea,
  output logic [`SDMA_ADDR_W-1:0] o_ahb_addr,
  output logic [`SDMA_DATA_W-1:0] o_ahb_wdata,
  input  logic                    i_ahb_ready,
  input  logic                    i_ahb_rvld,
  input  logic [`SDMA_DATA_W-1:0] i_ahb_rdata,
  // data cache
  output logic                    o_dc_req,
  output logic                    o_dc_wea,
  output logic [`SDMA_ADDR_W-1:0] o_dc_addr,
  output logic [`SDMA_DATA_W-1:0] o_dc_wdata,
  input  logic                    i_dc_ready,
  input  logic                    i_dc_rvld,
  input  logic [`SDMA_DATA_W-1:0] i_dc_rdata,
  // weight memory
  output logic                    o_wm_req,
  output logic                    o_wm_wea,
  output logic [`SDMA_ADDR_W-1:0] o_wm_addr,
  output logic [`SDMA_DATA_W-1:0] o_wm_wdata,
  input  logic                    i_wm_ready,
  input  logic                    i_wm_rvld,
  input  logic [`SDMA_DATA_W-1:0] i_wm_rdata,
  // bias memory
  output logic                    o_bm_req,
  output logic                    o_bm_wea,
  output logic [`SDMA_ADDR_W-1:0] o_bm_addr,
  output logic [`SDMA_DATA_W-1:0] o_bm_wdata,
  input  logic                    i_bm_ready,
  input  logic                    i_bm_rvld,
  input  logic [`SDMA_DATA_W-1:0] i_bm_rdata
);

  // --------------------
  // Wires
  // --------------------
  logic                    start;
  logic                    move_done;
  logic [1:0]              op;
  logic [1:0]              src_port;
  logic [1:0]              dst_port;
  logic [`SDMA_ADDR_W-1:0] src_addr;
  logic [`SDMA_ADDR_W-1:0] dst_addr;
  logic [`SDMA_LEN_W-1:0]  len;
  logic                    rd_req;
  logic                    rd_ready;
  logic                    rd_vld;
  logic [`SDMA_ADDR_W-1:0] rd_addr;
  logic [`SDMA_DATA_W-1:0] rd_data;
  logic                    wr_req;
  logic                    wr_ready;
  logic                    wr_zero;
  logic [`SDMA_ADDR_W-1:0] wr_addr;
  logic                    buf_pop;
  logic                    buf_empty;
  logic [`SDMA_DATA_W-1:0] buf_data;

  // --------------------
  // Instances
  // --------------------
  sdma_inst_ctrl u_inst_ctrl (
    .i_clk           (i_clk),
    .i_rst_n         (i_rst_n),
    .i_sdma_en       (i_sdma_en),
    .i_sdma_inst_vld (i_sdma_inst_vld),
    .i_sdma_inst     (i_sdma_inst),
    .i_move_done     (move_done),
    .o_sdma_ready    (o_sdma_ready),
    .o_sdma_done     (o_sdma_done),
    .o_sdma_err      (o_sdma_err),
    .o_start         (start),
    .o_op            (op),
    .o_src_port      (src_port),
    .o_dst_port      (dst_port),
    .o_src_addr      (src_addr),
    .o_dst_addr      (dst_addr),
    .o_len           (len)
  );

  sdma_move_engine u_move_engine (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_start     (start),
    .i_op        (op),
    .i_src_addr  (src_addr),
    .i_dst_addr  (dst_addr),
    .i_len       (len),
    .i_rd_ready  (rd_ready),
    .i_rd_vld    (rd_vld),
    .i_wr_ready  (wr_ready),
    .i_buf_empty (buf_empty),
    .o_rd_req    (rd_req),
    .o_rd_addr   (rd_addr),
    .o_wr_req    (wr_req),
    .o_wr_addr   (wr_addr),
    .o_wr_zero   (wr_zero),
    .o_buf_pop   (buf_pop),
    .o_move_done (move_done)
  );

  sdma_data_buf u_data_buf (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_push  (rd_vld),
    .i_data  (rd_data),
    .i_pop   (buf_pop),
    .o_data  (buf_data),
    .o_empty (buf_empty)
  );

  sdma_port_mux u_port_mux (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_src_port  (src_port),
    .i_dst_port  (dst_port),
    .i_rd_req    (rd_req),
    .i_rd_addr   (rd_addr),
    .i_wr_req    (wr_req),
    .i_wr_addr   (wr_addr),
    .i_wr_zero   (wr_zero),
    .i_buf_data  (buf_data),
    .o_rd_ready  (rd_ready),
    .o_wr_ready  (wr_ready),
    .o_rd_vld    (rd_vld),
    .o_rd_data   (rd_data),
    .o_ahb_req   (o_ahb_req),
    .o_ahb_wea   (o_ahb_wea),
    .o_ahb_addr  (o_ahb_addr),
    .o_ahb_wdata (o_ahb_wdata),
    .i_ahb_ready (i_ahb_ready),
    .i_ahb_rvld  (i_ahb_rvld),
    .i_ahb_rdata (i_ahb_rdata),
    .o_dc_req    (o_dc_req),
    .o_dc_wea    (o_dc_wea),
    .o_dc_addr   (o_dc_addr),
    .o_dc_wdata  (o_dc_wdata),
    .i_dc_ready  (i_dc_ready),
    .i_dc_rvld   (i_dc_rvld),
    .i_dc_rdata  (i_dc_rdata),
    .o_wm_req    (o_wm_req),
    .o_wm_wea    (o_wm_wea),
    .o_wm_addr   (o_wm_addr),
    .o_wm_wdata  (o_wm_wdata),
    .i_wm_ready  (i_wm_ready),
    .i_wm_rvld   (i_wm_rvld),
    .i_wm_rdata  (i_wm_rdata),
    .o_bm_req    (o_bm_req),
    .o_bm_wea    (o_bm_wea),
    .o_bm_addr   (o_bm_addr),
    .o_bm_wdata  (o_bm_wdata),
    .i_bm_ready  (i_bm_ready),
    .i_bm_rvld   (i_bm_rvld),
    .i_bm_rdata  (i_bm_rdata)
  );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the DMA testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module sdma_tb \
  -f sdma_top.f -Mdir obj_dir -o sdma_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sdma_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Test failed" "$LOG"; then
  exit 1
fi
exit 0

/* sdma_top.f */
+incdir+hdl
hdl/sdma_pkg.sv
hdl/sdma_inst_ctrl.sv
hdl/sdma_move_engine.sv
hdl/sdma_data_buf.sv
hdl/sdma_port_mux.sv
hdl/sdma_top.sv
sim/sdma_chk.sv
sim/sdma_tb.sv

/* sim/sdma_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module sdma_chk (
  input  logic        i_clk,
  input  logic        i_rst_n,
  input  logic        i_inst_vld,
  input  logic        i_ready,
  input  logic        i_done,
  input  logic        i_err,
  // Port order ahb, dc, wm, bm from bit 0
  input  logic [3:0]  i_req,
  input  logic [3:0]  i_port_ready,
  input  logic [63:0] i_addr
);

  logic in_xfer_q;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      in_xfer_q <= 1'b0;
    end else if (i_inst_vld && i_ready) begin
      in_xfer_q <= 1'b1;
    end else if (i_done || i_err) begin
      in_xfer_q <= 1'b0;
    end
  end

  a_ready_low: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    in_xfer_q && !i_done && !i_err |-> !i_ready)
    else $error("ready high while an instruction is in progress");

  a_done_err: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !(i_done && i_err))
    else $error("done and err high in the same cycle");

  a_wc_one_hot: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !(i_req[2] && i_req[3]))
    else $error("weight and bias memory requested together");

  // Stalled request keeps its address
  for (genvar p = 0; p < 4; p++) begin : g_hold
    a_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_req[p] && !i_port_ready[p] |=> i_req[p] && $stable(i_addr[p*16 +: 16]))
      else $error("port %0d request moved while stalled", p);
  end

endmodule

`default_nettype wire

/* sim/sdma_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sdma_defines.svh"

module sdma_tb import sdma_pkg::*; ();

  localparam int TIMEOUT = 4000;
  localparam int MEM_N   = 65536;

  typedef struct {
    string      name;
    sdma_op_e   op;
    sdma_port_e src;
    sdma_port_e dst;
    sdma_addr_t sa;
    sdma_addr_t da;
    sdma_len_t  len;
    bit         exp_err;
  } test_t;

  logic                    i_clk;
  logic                    i_rst_n;
  logic                    i_sdma_en;
  logic                    i_sdma_inst_vld;
  logic [`SDMA_INST_W-1:0] i_sdma_inst;
  logic                    o_sdma_ready;
  logic                    o_sdma_done;
  logic                    o_sdma_err;

  // Memory index 0 ahb, 1 dc, 2 wm, 3 bm
  logic [3:0] p_req;
  logic [3:0] p_wea;
  logic [3:0] p_ready;
  logic [3:0] p_rvld;
  sdma_addr_t p_addr [4];
  sdma_word_t p_wdata [4];
  sdma_word_t p_rdata [4];

  sdma_word_t  mem [4][MEM_N];
  sdma_word_t  ref_mem [4][MEM_N];
  logic [31:0] rng;
  int          acc_cnt;
  int          rd_cnt;
  int          done_cnt;
  int          checks;
  int          errors;
  test_t       tbl [$];

  sdma_top dut0 (
    .i_clk (i_clk), .i_rst_n (i_rst_n), .i_sdma_en (i_sdma_en),
    .i_sdma_inst_vld (i_sdma_inst_vld), .i_sdma_inst (i_sdma_inst),
    .o_sdma_ready (o_sdma_ready), .o_sdma_done (o_sdma_done), .o_sdma_err (o_sdma_err),
    .o_ahb_req (p_req[0]), .o_ahb_wea (p_wea[0]), .o_ahb_addr (p_addr[0]),
    .o_ahb_wdata (p_wdata[0]), .i_ahb_ready (p_ready[0]), .i_ahb_rvld (p_rvld[0]),
    .i_ahb_rdata (p_rdata[0]),
    .o_dc_req (p_req[1]), .o_dc_wea (p_wea[1]), .o_dc_addr (p_addr[1]),
    .o_dc_wdata (p_wdata[1]), .i_dc_ready (p_ready[1]), .i_dc_rvld (p_rvld[1]),
    .i_dc_rdata (p_rdata[1]),
    .o_wm_req (p_req[2]), .o_wm_wea (p_wea[2]), .o_wm_addr (p_addr[2]),
    .o_wm_wdata (p_wdata[2]), .i_wm_ready (p_ready[2]), .i_wm_rvld (p_rvld[2]),
    .i_wm_rdata (p_rdata[2]),
    .o_bm_req (p_req[3]), .o_bm_wea (p_wea[3]), .o_bm_addr (p_addr[3]),
    .o_bm_wdata (p_wdata[3]), .i_bm_ready (p_ready[3]), .i_bm_rvld (p_rvld[3]),
    .i_bm_rdata (p_rdata[3])
  );

  bind sdma_top sdma_chk u_chk (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_inst_vld   (i_sdma_inst_vld),
    .i_ready      (o_sdma_ready),
    .i_done       (o_sdma_done),
    .i_err        (o_sdma_err),
    .i_req        ({o_bm_req, o_wm_req, o_dc_req, o_ahb_req}),
    .i_port_ready ({i_bm_ready, i_wm_ready, i_dc_ready, i_ahb_ready}),
    .i_addr       ({o_bm_addr, o_wm_addr, o_dc_addr, o_ahb_addr})
  );

  initial begin
    i_clk = 1'b0;
    forever #4 i_clk = ~i_clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // --------------------
  // Memory models
  // --------------------
  initial begin : mem_model
    logic [3:0] s_acc;
    logic [3:0] s_wea;
    sdma_addr_t s_addr [4];
    sdma_word_t s_wdata [4];
    p_ready = '0;
    p_rvld  = '0;
    rng     = 32'h24ab_9c09;
    for (int p = 0; p < 4; p++) begin
      p_rdata[p] = '0;
      for (int a = 0; a < MEM_N; a++) begin
        rng           = xorshift32(rng);
        mem[p][a]     = rng;
        ref_mem[p][a] = rng;
      end
    end
    forever begin
      // Sample the request just before the edge that accepts it
      @(negedge i_clk);
      for (int p = 0; p < 4; p++) begin
        s_acc[p]   = p_req[p] & p_ready[p];
        s_wea[p]   = p_wea[p];
        s_addr[p]  = p_addr[p];
        s_wdata[p] = p_wdata[p];
        if (s_acc[p]) acc_cnt++;
        if (s_acc[p] && !s_wea[p]) rd_cnt++;
      end
      if (o_sdma_done) done_cnt++;
      @(posedge i_clk);
      #1;
      for (int p = 0; p < 4; p++) begin
        p_rvld[p]  = s_acc[p] & ~s_wea[p];
        p_rdata[p] = p_rvld[p] ? mem[p][s_addr[p]] : '0;
        if (s_acc[p] && s_wea[p]) mem[p][s_addr[p]] = s_wdata[p];
        rng        = xorshift32(rng);
        p_ready[p] = (rng[1:0] != 2'b00);
      end
    end
  end

  // --------------------
  // Reference model
  // --------------------
  function automatic bit in_window(input sdma_addr_t a, input sdma_addr_t lo,
                                   input sdma_addr_t hi);
    return (a >= lo) && (a <= hi);
  endfunction

  function automatic sdma_word_t ref_read(input sdma_port_e port, input sdma_addr_t a);
    if (port == port_ahb) return ref_mem[0][a];
    if (port == port_dc) return ref_mem[1][a];
    if (in_window(a, `SDMA_WMEM_SADDR, `SDMA_WMEM_EADDR))
      return ref_mem[2][sdma_addr_t'(a - `SDMA_WMEM_SADDR)];
    if (in_window(a, `SDMA_BMEM_SADDR, `SDMA_BMEM_EADDR))
      return ref_mem[3][sdma_addr_t'(a - `SDMA_BMEM_SADDR)];
    return '0;
  endfunction

  task automatic ref_write(input sdma_port_e port, input sdma_addr_t a, input sdma_word_t d);
    if (port == port_ahb) ref_mem[0][a] = d;
    else if (port == port_dc) ref_mem[1][a] = d;
    else if (in_window(a, `SDMA_WMEM_SADDR, `SDMA_WMEM_EADDR))
      ref_mem[2][sdma_addr_t'(a - `SDMA_WMEM_SADDR)] = d;
    else if (in_window(a, `SDMA_BMEM_SADDR, `SDMA_BMEM_EADDR))
      ref_mem[3][sdma_addr_t'(a - `SDMA_BMEM_SADDR)] = d;
  endtask

  task automatic ref_apply(input test_t t);
    sdma_word_t d;
    if (!t.exp_err) begin
      for (int i = 0; i < int'(t.len); i++) begin
        d = (t.op == op_zero) ? '0 : ref_read(t.src, t.sa + sdma_addr_t'(i));
        ref_write(t.dst, t.da + sdma_addr_t'(i), d);
      end
    end
  endtask

  // --------------------
  // Checks
  // --------------------
  task automatic check_word(input string name, input sdma_word_t exp, input sdma_word_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("ERROR %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input bit exp, input bit act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("ERROR %s: expected %0b, actual %0b", name, exp, act);
    end
  endtask

  task automatic compare_mems(input string name);
    bit bad;
    bad = 1'b0;
    for (int p = 0; p < 4; p++) begin
      for (int a = 0; a < MEM_N && !bad; a++) begin
        if (mem[p][a] !== ref_mem[p][a]) begin
          bad = 1'b1;
          check_word($sformatf("%s mem%0d[%h]", name, p, a), ref_mem[p][a], mem[p][a]);
        end
      end
    end
    if (!bad) checks++;
  endtask

  task automatic add_test(input string name, input sdma_op_e op, input sdma_port_e src,
                          input sdma_port_e dst, input sdma_addr_t sa, input sdma_addr_t da,
                          input sdma_len_t len, input bit exp_err);
    test_t t;
    t.name    = name;
    t.op      = op;
    t.src     = src;
    t.dst     = dst;
    t.sa      = sa;
    t.da      = da;
    t.len     = len;
    t.exp_err = exp_err;
    tbl.push_back(t);
  endtask

  // --------------------
  // Stimulus
  // --------------------
  initial begin : main
    test_t t;
    int    n;
    int    err0;
    int    acc0;
    int    rd0;
    int    legal;
    bit    timed_out;
    i_rst_n         = 1'b0;
    i_sdma_en       = 1'b1;
    i_sdma_inst_vld = 1'b0;
    i_sdma_inst     = '0;
    timed_out       = 1'b0;
    legal           = 0;
    //       name            op       src        dst        src addr  dst addr  len  err
    add_test("ahb_to_dc",    op_move, port_ahb,  port_dc,   16'h0100, 16'h0200, 12,  1'b0);
    add_test("dc_to_wmem",   op_move, port_dc,   port_wc,   16'h0300, 16'h0040, 8,   1'b0);
    add_test("wc_span",      op_move, port_wc,   port_ahb,  16'h0ffe, 16'h0400, 6,   1'b0);
    add_test("zero_dc",      op_zero, port_ahb,  port_dc,   16'h0000, 16'h0500, 10,  1'b0);
    add_test("wr_absorb",    op_move, port_ahb,  port_wc,   16'h0600, 16'h2000, 5,   1'b0);
    add_test("rd_absorb",    op_move, port_wc,   port_dc,   16'h2000, 16'h0700, 5,   1'b0);
    add_test("rsvd_src",     op_move, port_rsvd, port_dc,   16'h0000, 16'h0800, 4,   1'b1);
    add_test("len_zero",     op_move, port_ahb,  port_dc,   16'h0010, 16'h0900, 0,   1'b0);
    add_test("dc_to_dc",     op_move, port_dc,   port_dc,   16'h0a00, 16'h0b00, 20,  1'b0);
    add_test("ahb_to_bmem",  op_move, port_ahb,  port_wc,   16'h0c00, 16'h1010, 7,   1'b0);
    add_test("zero_rsvd",    op_zero, port_ahb,  port_rsvd, 16'h0000, 16'h0100, 3,   1'b1);
    add_test("wmem_to_bmem", op_move, port_wc,   port_wc,   16'h0010, 16'h1100, 9,   1'b0);
    add_test("ahb_long",     op_move, port_ahb,  port_dc,   16'h1000, 16'h1000, 40,  1'b0);

    repeat (8) @(posedge i_clk);
    #1;
    check_flag("reset ready", 1'b0, o_sdma_ready);
    check_flag("reset pulses", 1'b0, o_sdma_done | o_sdma_err);
    check_flag("reset requests", 1'b0, |p_req);
    $display("test %-14s errors %0d", "reset", errors);
    i_rst_n = 1'b1;

    for (int i = 0; i < tbl.size() && !timed_out; i++) begin
      t    = tbl[i];
      err0 = errors;
      acc0 = acc_cnt;
      rd0  = rd_cnt;
      n    = 0;
      while (!o_sdma_ready && n < TIMEOUT) begin
        @(posedge i_clk);
        #1;
        n++;
      end
      if (!o_sdma_ready) begin
        $display("Timeout waiting for ready before test %s", t.name);
        timed_out = 1'b1;
      end else begin
        i_sdma_inst     = {t.op, t.src, t.dst, t.sa, t.da, t.len};
        i_sdma_inst_vld = 1'b1;
        @(posedge i_clk);
        #1;
        i_sdma_inst_vld = 1'b0;
        n = 0;
        while (!o_sdma_done && !o_sdma_err && n < TIMEOUT) begin
          @(posedge i_clk);
          #1;
          n++;
        end
        if (!o_sdma_done && !o_sdma_err) begin
          $display("Timeout waiting for done or err in test %s", t.name);
          timed_out = 1'b1;
        end else begin
          check_flag({t.name, " done"}, !t.exp_err, o_sdma_done);
          check_flag({t.name, " err"}, t.exp_err, o_sdma_err);
          // Err and zero length end in the cycle after acceptance
          if (t.exp_err || t.len == '0) check_flag({t.name, " latency"}, 1'b1, n == 0);
          if (!t.exp_err) legal++;
          // Last write lands in the memory model one edge later
          @(posedge i_clk);
          #1;
          if (t.exp_err) check_flag({t.name, " no access"}, 1'b1, acc_cnt == acc0);
          if (t.op == op_zero) check_flag({t.name, " no read"}, 1'b1, rd_cnt == rd0);
          ref_apply(t);
          compare_mems(t.name);
          $display("test %-14s errors %0d", t.name, errors - err0);
        end
      end
    end

    check_flag("done count", 1'b1, done_cnt == legal);
    $display("tests %0d, checks %0d, errors %0d, done pulses %0d",
             tbl.size(), checks, errors, done_cnt);
    if (errors == 0 && !timed_out) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
